/* dtag_cache.f */
hw/dtag_pkg.sv
hw/tag_bank.sv
hw/dtag_banks.sv
hw/way_select_counter.sv
hw/fill_controller.sv
hw/dtag_top.sv
verification/dtag_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the tag pipeline testbench with verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f dtag_cache.f --top-module dtag_tb -o dtag_sim
./obj_dir/dtag_sim | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* verification/dtag_stim.txt */
# op addr flag, all hex: op 0 lookup, 1 inv-lookup, 2 snoop, 3 random burst
# addr is the word address (burst: lookup count), flag is the expected hit
0 0000004c 0
0 0000004d 1
0 0000008c 0
0 000000cc 0
0 0000010c 0
0 0000014c 0
0 0000008e 1
0 000000cf 1
0 0000010d 1
0 0000014c 1
0 0000004c 0
1 000000cc 1
0 0000014c 0
0 000000cc 0
0 00000040 0
0 00000080 0
2 00000040 1
0 00000081 1
0 00000040 0
2 00000100 0
3 00000030 0

/* verification/dtag_tb.sv */
// testbench for the data cache tag pipeline
// replays the stim file against a behavioral tag model, answers fill requests itself
module dtag_tb;
    import dtag_pkg::*;

    localparam int WAYS   = 4;
    localparam int LINES  = 16;
    localparam int LINE_W = $clog2(LINES);
    localparam int TAG_W  = ADDR_W - LINE_W - SUB_LINE_W;

    logic              clk = 1'b0;
    logic              rst = 1'b1;
    lookup_req_t       req;
    lookup_resp_t      resp;
    logic              ready;
    logic [WAYS-1:0]   resp_way;
    logic              fill_req;
    logic [ADDR_W-1:0] fill_addr;
    logic              fill_done = 1'b0;
    logic              snoop_inv;
    logic [ADDR_W-1:0] snoop_addr;
    logic              snoop_done;

    logic [TAG_W-1:0]  m_tag [LINES][WAYS];  // model tag array
    logic              m_val [LINES][WAYS];
    int                m_victim = 0;         // one pointer for all sets
    lookup_req_t       issue_q [$];          // waiting for ready
    lookup_req_t       flight_q [$];         // accepted, response due
    logic [ADDR_W-1:0] exp_fill_addr;
    int                n_ops = 0;
    int                errors = 0;
    int                fills_exp = 0;
    int                fills_seen = 0;
    int                fill_cnt = 0;

    dtag_top #(.WAYS(WAYS), .LINES(LINES)) UUT (.*);

    always #2 clk = ~clk;  // period 4

    // outside memory, fill_done three cycles into fill_req
    always @(posedge clk) begin
        #1;
        if (fill_done) begin
            fill_done = 1'b0;  // single cycle pulse
            fill_cnt  = 0;
        end else if (fill_req) begin
            fill_cnt++;
            if (fill_cnt == 3) begin
                fill_done = 1'b1;
                fills_seen++;
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERR t=%0t %s got %0h expected %0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic report_fault(input string what);
        $display("t=%0t %s", $time, what);
        errors++;
    endtask

    // one-hot of model ways holding this line
    function automatic logic [WAYS-1:0] model_ways(input logic [ADDR_W-1:0] addr);
        logic [WAYS-1:0] hits;
        int              line;
        line = int'(addr[SUB_LINE_W +: LINE_W]);
        for (int w = 0; w < WAYS; w++) begin
            hits[w] = m_val[line][w] && (m_tag[line][w] == addr[ADDR_W-1 -: TAG_W]);
        end
        return hits;
    endfunction

    // compare one response, then apply its effect to the model
    task automatic check_resp();
        lookup_req_t     sent;
        logic [WAYS-1:0] exp_way;
        int              line;
        sent    = flight_q.pop_front();
        exp_way = model_ways(sent.addr);
        line    = int'(sent.addr[SUB_LINE_W +: LINE_W]);
        if (resp.addr !== sent.addr)
            report_mismatch("resp.addr", 32'(resp.addr), 32'(sent.addr));
        if (resp.inv !== sent.inv)
            report_mismatch("resp.inv", 32'(resp.inv), 32'(sent.inv));
        if (resp.hit !== (exp_way != '0))
            report_mismatch("resp.hit", 32'(resp.hit), 32'(exp_way != '0));
        if (resp_way !== exp_way)
            report_mismatch("resp_way", 32'(resp_way), 32'(exp_way));
        if (sent.inv) begin
            for (int w = 0; w < WAYS; w++) m_val[line][w] = 1'b0;  // whole set cleared
        end else if (exp_way == '0) begin
            if (ready) report_fault("ready stayed high in the miss cycle");
            m_val[line][m_victim] = 1'b1;
            m_tag[line][m_victim] = sent.addr[ADDR_W-1 -: TAG_W];
            m_victim      = (m_victim + 1) % WAYS;
            exp_fill_addr = {sent.addr[ADDR_W-1:SUB_LINE_W], {SUB_LINE_W{1'b0}}};
            fills_exp++;
        end
    endtask

    // back to back issue of issue_q, each response one cycle after accept
    task automatic run_lookups();
        logic accepted;
        logic pending;
        pending = 1'b0;
        while (issue_q.size() > 0 || flight_q.size() > 0) begin
            if (!req.valid && issue_q.size() > 0) req = issue_q.pop_front();
            @(negedge clk);
            if (resp.valid && flight_q.size() == 0) begin
                report_fault("response without an accepted request");
            end else if (resp.valid) begin
                check_resp();
            end else if (pending) begin
                report_fault("no response one cycle after accept");
                void'(flight_q.pop_front());
            end
            if (fill_req && fill_addr !== exp_fill_addr)
                report_mismatch("fill_addr", 32'(fill_addr), 32'(exp_fill_addr));
            accepted = req.valid && ready;
            @(posedge clk);
            #1;
            pending = accepted;
            if (accepted) begin
                flight_q.push_back(req);
                req = '0;
            end
        end
        while (!ready) begin  // trailing fill
            if (fill_req && fill_addr !== exp_fill_addr)
                report_mismatch("fill_addr", 32'(fill_addr), 32'(exp_fill_addr));
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_snoop(input logic [ADDR_W-1:0] addr, input logic flag);
        logic [WAYS-1:0] exp_way;
        int              cycles;
        exp_way = model_ways(addr);
        if ((exp_way != '0) !== flag) report_fault("stim hit flag disagrees with the tag model");
        snoop_inv  = 1'b1;
        snoop_addr = addr;
        cycles     = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!snoop_done);
        if (cycles != 2) report_mismatch("snoop_done cycle", 32'(cycles), 2);
        @(posedge clk);
        #1;
        snoop_inv = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (exp_way[w]) m_val[int'(addr[SUB_LINE_W +: LINE_W])][w] = 1'b0;  // hit way only
        end
    endtask

    initial begin
        int              fd;
        int              errs_before;
        int              op;
        logic [31:0]     addr;
        logic [31:0]     flag;
        logic [31:0]     seed;
        logic [WAYS-1:0] exp_way;
        lookup_req_t     r;
        string           text;
        int              ops [$];
        logic [31:0]     addrs [$];
        logic [31:0]     flags [$];
        req        = '0;
        snoop_inv  = 1'b0;
        snoop_addr = '0;
        seed       = 32'h622aeeef;
        for (int l = 0; l < LINES; l++) begin
            for (int w = 0; w < WAYS; w++) m_val[l][w] = 1'b0;
        end
        fd = $fopen("verification/dtag_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stim file");
            $display("Test failures found");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                text = "";
                void'($fgets(text, fd));
                if (text.len() > 1 && text[0] != "#") begin  // skip comments and blanks
                    if ($sscanf(text, "%h %h %h", op, addr, flag) == 3) begin
                        ops.push_back(op);
                        addrs.push_back(addr);
                        flags.push_back(flag);
                    end
                end
            end
            $fclose(fd);
            n_ops = ops.size();  // starts the watchdog
            repeat (4) @(posedge clk);
            #1;
            rst = 1'b0;
            if (ready !== 1'b1) report_mismatch("ready", 32'(ready), 1);
            if (fill_req !== 1'b0) report_mismatch("fill_req", 32'(fill_req), 0);
            if (snoop_done !== 1'b0) report_mismatch("snoop_done", 32'(snoop_done), 0);
            $display("reset: %s", (errors == 0) ? "ok" : "failed");
            for (int t = 0; t < n_ops; t++) begin
                errs_before = errors;
                case (ops[t])
                    0, 1: begin
                        exp_way = model_ways(addrs[t][ADDR_W-1:0]);
                        if ((exp_way != '0) !== flags[t][0])
                            report_fault("stim hit flag disagrees with the tag model");
                        r       = '0;
                        r.valid = 1'b1;
                        r.inv   = (ops[t] == 1);
                        r.addr  = addrs[t][ADDR_W-1:0];
                        issue_q.push_back(r);
                        run_lookups();
                    end
                    2: run_snoop(addrs[t][ADDR_W-1:0], flags[t][0]);
                    3: begin
                        for (int i = 0; i < int'(addrs[t]); i++) begin
                            seed    = xorshift32(seed);
                            r       = '0;
                            r.valid = 1'b1;
                            r.addr[ADDR_W-1 -: TAG_W]    = TAG_W'(seed % 6);  // six tags, four ways
                            r.addr[SUB_LINE_W +: LINE_W] = LINE_W'(seed[9:8]);  // sets 0 to 3
                            r.addr[SUB_LINE_W-1:0]       = seed[17:16];
                            issue_q.push_back(r);
                        end
                        run_lookups();
                    end
                    default: report_fault("unknown op code in the stim file");
                endcase
                if (fills_seen != fills_exp) report_mismatch("fill count", fills_seen, fills_exp);
                $display("test %0d op %0d addr %h: %s", t + 1, ops[t], addrs[t],
                         (errors == errs_before) ? "ok" : "failed");
            end
            $display("%0d tests run, %0d errors", n_ops, errors);
            if (errors == 0) begin
                $display("All tests passed!");
            end else begin
                $display("Test failures found");
            end
            $finish;
        end
    end

    // watchdog scaled by stim length
    initial begin
        wait (n_ops > 0);
        repeat (n_ops * 40 + 200) @(posedge clk);
        $display("timeout waiting on the DUT, fill state %0d ready %b", UUT.u_fill.state, ready);
        $display("Test failures found");
        $finish;
    end

endmodule

/* hw/dtag_top.sv */
// data cache tag pipeline top level
// stage 1 reads all ways, stage 2 compares and reports hit and way
// misses go out as fill requests, snoops invalidate through port b
module dtag_top #(
    parameter int WAYS  = 4,
    parameter int LINES = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  dtag_pkg::lookup_req_t       req,
    output logic                        ready,
    output dtag_pkg::lookup_resp_t      resp,
    output logic [WAYS-1:0]             resp_way,
    output logic                        fill_req,
    output logic [dtag_pkg::ADDR_W-1:0] fill_addr,
    input  logic                        fill_done,
    input  logic                        snoop_inv,
    input  logic [dtag_pkg::ADDR_W-1:0] snoop_addr,
    output logic                        snoop_done
);
    import dtag_pkg::*;

    lookup_req_t       stage2_req;
    logic              stage2_valid;
    logic              stage1_adv;
    logic [ADDR_W-1:0] bank_stage2_addr;
    logic [ADDR_W-1:0] update_addr;
    logic              update;
    logic              tag_hit;
    logic [WAYS-1:0]   tag_hit_way;
    logic [WAYS-1:0]   victim_way;

    assign stage1_adv = req.valid & ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage2_valid <= 1'b0;
        end else begin
            stage2_valid <= stage1_adv;  // one response per accept
        end
    end

    always_ff @(posedge clk) begin
        if (stage1_adv) stage2_req <= req;
    end

    // fill address takes over the compare/update path during the write
    assign bank_stage2_addr = update ? update_addr : stage2_req.addr;

    assign resp     = '{valid: stage2_valid, hit: tag_hit, inv: stage2_req.inv,
                        addr: stage2_req.addr};
    assign resp_way = tag_hit_way;

    dtag_banks #(
        .WAYS  (WAYS),
        .LINES (LINES)
    ) u_banks (
        .clk         (clk),
        .rst         (rst),
        .stage1_addr (req.addr),
        .stage2_addr (bank_stage2_addr),
        .snoop_addr  (snoop_addr),
        .update_way  (victim_way),
        .update      (update),
        .stage1_adv  (stage1_adv),
        .stage1_inv  (req.inv),
        .snoop_inv   (snoop_inv),
        .snoop_done  (snoop_done),
        .tag_hit     (tag_hit),
        .tag_hit_way (tag_hit_way)
    );

    way_select_counter #(
        .WAYS (WAYS)
    ) u_victim (
        .clk        (clk),
        .rst        (rst),
        .advance    (update),
        .victim_way (victim_way)
    );

    fill_controller #(
        .LINES (LINES)
    ) u_fill (
        .clk         (clk),
        .rst         (rst),
        .resp        (resp),
        .fill_done   (fill_done),
        .ready       (ready),
        .fill_req    (fill_req),
        .fill_addr   (fill_addr),
        .update      (update),
        .update_addr (update_addr)
    );

endmodule

/* hw/fill_controller.sv */
// miss handling for the tag pipeline
// stalls lookups on a miss, requests the line, then writes the new tag once
module fill_controller #(
    parameter int LINES = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  dtag_pkg::lookup_resp_t      resp,
    input  logic                        fill_done,
    output logic                        ready,
    output logic                        fill_req,
    output logic [dtag_pkg::ADDR_W-1:0] fill_addr,
    output logic                        update,
    output logic [dtag_pkg::ADDR_W-1:0] update_addr
);
    import dtag_pkg::*;

    localparam int LINE_W = $clog2(LINES);
    localparam int TAG_W  = ADDR_W - LINE_W - SUB_LINE_W;

    fill_state_t state;
    fill_state_t next_state;
    lookup_req_t miss_req;   // request being filled
    logic        miss;

    assign miss = resp.valid & ~resp.hit & ~resp.inv;  // inv lookups never fill

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (miss) next_state = st_request;
            end
            st_request: begin
                next_state = fill_done ? st_update : st_wait_fill;
            end
            st_wait_fill: begin
                if (fill_done) next_state = st_update;
            end
            st_update: begin
                next_state = st_idle;  // single cycle write
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // hold the missing address for the whole fill
    always_ff @(posedge clk) begin
        if (state == st_idle && miss) begin
            miss_req <= '{valid: 1'b1, inv: 1'b0, addr: resp.addr};
        end
    end

    assign ready       = (state == st_idle) & ~miss;  // drops in the miss cycle
    assign fill_req    = (state == st_request) | (state == st_wait_fill);
    assign update      = (state == st_update);
    assign update_addr = miss_req.addr;
    // line aligned, word bits cleared
    assign fill_addr   = {miss_req.addr[ADDR_W-1 -: TAG_W + LINE_W], {SUB_LINE_W{1'b0}}};

    // a response during a fill would lose its miss
    a_no_resp_in_fill: assert property (@(posedge clk) disable iff (rst)
        resp.valid |-> (state == st_idle));

endmodule

/* hw/way_select_counter.sv */
// round-robin victim pointer for line fills
// one-hot, rotates to the next way after every tag update
module way_select_counter #(
    parameter int WAYS = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            advance,     // fill update this cycle
    output logic [WAYS-1:0] victim_way
);

    always_ff @(posedge clk) begin
        if (rst) begin
            victim_way <= WAYS'(1);  // way 0 first
        end else if (advance) begin
            // rotate left, top way wraps to way 0
            victim_way <= (victim_way << 1) | (victim_way >> (WAYS - 1));
        end
    end

    // bank write enables assume exactly one victim
    a_victim_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot(victim_way));

endmodule

/* hw/dtag_banks.sv */
// tag storage for all ways plus hit detection
// lookups read port a, fills and snoop invalidates share port b
// a snoop reads in its first cycle and clears hit ways in its second
module dtag_banks #(
    parameter int WAYS  = 4,
    parameter int LINES = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [dtag_pkg::ADDR_W-1:0] stage1_addr,
    input  logic [dtag_pkg::ADDR_W-1:0] stage2_addr,
    input  logic [dtag_pkg::ADDR_W-1:0] snoop_addr,
    input  logic [WAYS-1:0]             update_way,
    input  logic                        update,
    input  logic                        stage1_adv,
    input  logic                        stage1_inv,
    input  logic                        snoop_inv,
    output logic                        snoop_done,
    output logic                        tag_hit,
    output logic [WAYS-1:0]             tag_hit_way
);
    import dtag_pkg::*;

    localparam int LINE_W = $clog2(LINES);
    localparam int TAG_W  = ADDR_W - LINE_W - SUB_LINE_W;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    function automatic logic [TAG_W-1:0] get_tag(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic logic [LINE_W-1:0] get_line(input logic [ADDR_W-1:0] addr);
        return addr[SUB_LINE_W +: LINE_W];
    endfunction

    tag_entry_t        lookup_entry [WAYS];  // port a read data
    tag_entry_t        snoop_entry [WAYS];   // port b read data
    tag_entry_t        lookup_cmp;
    tag_entry_t        snoop_cmp;
    tag_entry_t        new_entry;
    logic [WAYS-1:0]   snoop_hit_way;
    logic [WAYS-1:0]   port_b_wen;
    logic [LINE_W-1:0] port_b_addr;
    logic              snoop_accessed;  // snoop set was read last cycle

    // fill update has priority on port b
    assign port_b_addr = update ? get_line(stage2_addr) : get_line(snoop_addr);
    assign new_entry   = '{valid: update, tag: get_tag(stage2_addr)};  // invalid for snoop

    // first snoop cycle reads, second one completes unless a fill took port b
    always_ff @(posedge clk) begin
        if (rst) begin
            snoop_accessed <= 1'b0;
        end else begin
            snoop_accessed <= snoop_inv & ~update & ~snoop_done;
        end
    end

    assign snoop_done = snoop_inv & ~update & snoop_accessed;

    assign lookup_cmp = '{valid: 1'b1, tag: get_tag(stage2_addr)};
    assign snoop_cmp  = '{valid: 1'b1, tag: get_tag(snoop_addr)};

    for (genvar i = 0; i < WAYS; i++) begin : g_way
        assign port_b_wen[i] = (update_way[i] & update) | (snoop_hit_way[i] & snoop_done);

        tag_bank #(
            .WIDTH ($bits(tag_entry_t)),
            .DEPTH (LINES)
        ) u_bank (
            .clk        (clk),
            .rst        (rst),
            .en_a       (stage1_adv),
            .wen_a      (stage1_inv),      // invalidate lookup clears every way
            .addr_a     (get_line(stage1_addr)),
            .data_in_a  ('0),
            .data_out_a (lookup_entry[i]),
            .en_b       (update | snoop_inv),
            .wen_b      (port_b_wen[i]),
            .addr_b     (port_b_addr),
            .data_in_b  (new_entry),
            .data_out_b (snoop_entry[i])
        );

        assign tag_hit_way[i]   = (lookup_entry[i] == lookup_cmp);
        assign snoop_hit_way[i] = (snoop_entry[i] == snoop_cmp);
    end

    assign tag_hit = |tag_hit_way;

    // fills only follow misses, so a tag lives in at most one way
    a_hit_onehot0: assert property (@(posedge clk) disable iff (rst)
        $onehot0(tag_hit_way));

endmodule

/* hw/tag_bank.sv */
// dual-port tag ram, one per way
// port a serves lookups, port b serves fills and snoops, reads are registered
module tag_bank #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     en_a,
    input  logic                     wen_a,
    input  logic [$clog2(DEPTH)-1:0] addr_a,
    input  logic [WIDTH-1:0]         data_in_a,
    output logic [WIDTH-1:0]         data_out_a,
    input  logic                     en_b,
    input  logic                     wen_b,
    input  logic [$clog2(DEPTH)-1:0] addr_b,
    input  logic [WIDTH-1:0]         data_in_b,
    output logic [WIDTH-1:0]         data_out_b
);
    logic [WIDTH-1:0] ram [DEPTH];

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            ram[i] = '0;  // every entry starts invalid
        end
    end

    // port b written last so it wins on a shared address
    always @(posedge clk) begin
        if (en_a && wen_a) begin
            ram[addr_a] <= data_in_a;
        end
        if (en_b && wen_b) begin
            ram[addr_b] <= data_in_b;
        end
    end

    // read-first on both ports
    always_ff @(posedge clk) begin
        if (rst) begin
            data_out_a <= '0;
            data_out_b <= '0;
        end else begin
            if (en_a) data_out_a <= ram[addr_a];
            if (en_b) data_out_b <= ram[addr_b];
        end
    end

    // lookup invalidate and fill/snoop traffic must not collide on one entry
    a_no_dual_write: assert property (@(posedge clk) disable iff (rst)
        !(en_a && wen_a && en_b && wen_b && (addr_a == addr_b)));

endmodule

/* hw/dtag_pkg.sv */
// shared constants and types for the data cache tag pipeline
// compile before the rtl, each module imports it inside its body
package dtag_pkg;

    localparam int ADDR_W     = 30;  // word address, byte bits dropped
    localparam int SUB_LINE_W = 2;   // four words per line

    // lookup request as presented by the load/store side
    typedef struct packed {
        logic              valid;
        logic              inv;   // clear the set instead of a plain lookup
        logic [ADDR_W-1:0] addr;
    } lookup_req_t;

    // stage-2 result, one per accepted request
    typedef struct packed {
        logic              valid;
        logic              hit;   // hit before any clearing
        logic              inv;   // invalidate lookups never start a fill
        logic [ADDR_W-1:0] addr;
    } lookup_resp_t;

    // miss handling sequence
    typedef enum logic [1:0] {
        st_idle,        // lookups flow
        st_request,     // first cycle of fill_req
        st_wait_fill,   // waiting on fill_done
        st_update       // one cycle tag write
    } fill_state_t;

endpackage
